/* design/flit_chan_if.sv */
//--------------------------------------------------------------------------
// Flit channel from an input port to the crossbar, with its route mask
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "router_defines.svh"

interface flit_chan_if;

  logic                         valid;
  logic                         ready;
  logic [`ROUTER_FLIT_W-1:0]    data;
  // One-hot output selection for the head flit
  logic [`ROUTER_NUM_PORTS-1:0] route;

  // Input port side
  modport src (
    output valid,
    output data,
    output route,
    input  ready
  );

  // Crossbar side
  modport dst (
    input  valid,
    input  data,
    input  route,
    output ready
  );

endinterface

/* design/router_defines.svh */
//--------------------------------------------------------------------------
// Mesh router constants: port indices, flit field layout and buffer depth
//--------------------------------------------------------------------------

`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// Number of router ports, four mesh directions plus local eject
`define ROUTER_NUM_PORTS 5

// Port indices, shared by every port array in the router
`define ROUTER_PORT_NORTH 0
`define ROUTER_PORT_EAST  1
`define ROUTER_PORT_SOUTH 2
`define ROUTER_PORT_WEST  3
`define ROUTER_PORT_EJECT 4

// Flit layout is {dst_x, dst_y, payload}
`define ROUTER_COORD_W   4
`define ROUTER_PAYLOAD_W 16
`define ROUTER_FLIT_W    (2 * `ROUTER_COORD_W + `ROUTER_PAYLOAD_W)

// MSB positions of the destination fields
`define ROUTER_DST_X_MSB (`ROUTER_FLIT_W - 1)
`define ROUTER_DST_Y_MSB (`ROUTER_FLIT_W - 1 - `ROUTER_COORD_W)

// Entries per input buffer
`define ROUTER_IN_FIFO_DEPTH 2

`endif

/* design/router_in_port.sv */
//--------------------------------------------------------------------------
// Router input port: small circular flit buffer and XY route of its head
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "router_defines.svh"

module router_in_port (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [2*`ROUTER_COORD_W-1:0]   xy_id_i,
  input  logic                           valid_i,
  output logic                           ready_o,
  input  logic [`ROUTER_FLIT_W-1:0]      data_i,
  flit_chan_if.src                       chan_o
);

  localparam int unsigned DEPTH = `ROUTER_IN_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [`ROUTER_FLIT_W-1:0]  mem_q [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [CNT_W-1:0]           count_q;
  logic                       push;
  logic                       pop;
  logic [`ROUTER_FLIT_W-1:0]  head;
  logic [`ROUTER_COORD_W-1:0] dst_x;
  logic [`ROUTER_COORD_W-1:0] dst_y;
  logic [`ROUTER_COORD_W-1:0] own_x;
  logic [`ROUTER_COORD_W-1:0] own_y;

  // Pointer advance with wrap at the buffer depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign push    = valid_i & ready_o;
  assign pop     = chan_o.valid & chan_o.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign head = mem_q[rd_ptr_q];

  // Destination fields of the head flit and own coordinates
  assign dst_x = head[`ROUTER_DST_X_MSB -: `ROUTER_COORD_W];
  assign dst_y = head[`ROUTER_DST_Y_MSB -: `ROUTER_COORD_W];
  assign own_x = xy_id_i[2*`ROUTER_COORD_W-1 -: `ROUTER_COORD_W];
  assign own_y = xy_id_i[`ROUTER_COORD_W-1:0];

  assign chan_o.valid = (count_q != '0);
  assign chan_o.data  = head;
  assign chan_o.route = router_pkg::xy_route(dst_x, dst_y, own_x, own_y);

endmodule

/* design/router_out_arbiter.sv */
//--------------------------------------------------------------------------
// Output arbiter: round-robin grant, held while the output is stalled
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "router_defines.svh"

module router_out_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic [`ROUTER_NUM_PORTS-1:0]                      req_i,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_FLIT_W-1:0]  data_i,
  input  logic                                              ready_i,
  output logic [`ROUTER_NUM_PORTS-1:0]                      gnt_o,
  output logic                                              valid_o,
  output logic [`ROUTER_FLIT_W-1:0]                         data_o
);

  localparam int unsigned N     = `ROUTER_NUM_PORTS;
  localparam int unsigned PTR_W = $clog2(N);

  logic [PTR_W-1:0] ptr_q;
  logic             lock_q;
  logic [N-1:0]     gnt_q;
  logic [N-1:0]     pick;
  logic [PTR_W-1:0] win_idx;

  // First requester at or after the pointer
  always_comb begin : pick_comb
    int unsigned idx;
    logic        found;
    pick  = '0;
    found = 1'b0;
    for (int unsigned i = 0; i < N; i++) begin
      idx = (int'(ptr_q) + i) % N;
      if (!found && req_i[idx]) begin
        found     = 1'b1;
        pick[idx] = 1'b1;
      end
    end
  end

  // A stalled output keeps its winner so data_o stays put
  assign gnt_o   = lock_q ? gnt_q : pick;
  assign valid_o = |gnt_o;

  always_comb begin
    data_o  = '0;
    win_idx = '0;
    for (int unsigned i = 0; i < N; i++) begin
      if (gnt_o[i]) begin
        data_o  = data_i[i];
        win_idx = PTR_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
      gnt_q  <= '0;
    end else begin
      lock_q <= valid_o & ~ready_i;
      gnt_q  <= gnt_o;
      // Winner drops to lowest priority after it transfers
      if (valid_o && ready_i) begin
        ptr_q <= (win_idx == PTR_W'(N - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

endmodule

/* design/router_pkg.sv */
//--------------------------------------------------------------------------
// Router package: XY route selection and crossbar connectivity rules
//--------------------------------------------------------------------------

`include "router_defines.svh"

package router_pkg;

  // Dimension-ordered routing, X first and then Y
  function automatic logic [`ROUTER_NUM_PORTS-1:0] xy_route(
    input logic [`ROUTER_COORD_W-1:0] dst_x,
    input logic [`ROUTER_COORD_W-1:0] dst_y,
    input logic [`ROUTER_COORD_W-1:0] own_x,
    input logic [`ROUTER_COORD_W-1:0] own_y
  );
    logic [`ROUTER_NUM_PORTS-1:0] sel;
    sel = '0;
    if (dst_x > own_x) begin
      sel[`ROUTER_PORT_EAST] = 1'b1;
    end else if (dst_x < own_x) begin
      sel[`ROUTER_PORT_WEST] = 1'b1;
    end else if (dst_y > own_y) begin
      sel[`ROUTER_PORT_NORTH] = 1'b1;
    end else if (dst_y < own_y) begin
      sel[`ROUTER_PORT_SOUTH] = 1'b1;
    end else begin
      sel[`ROUTER_PORT_EJECT] = 1'b1;
    end
    return sel;
  endfunction

  // Under XY routing a flit never turns back or goes from Y to X
  function automatic bit conn_allowed(
    input int unsigned in_idx,
    input int unsigned out_idx
  );
    bit y_in;
    bit x_out;
    y_in  = (in_idx == `ROUTER_PORT_NORTH) || (in_idx == `ROUTER_PORT_SOUTH);
    x_out = (out_idx == `ROUTER_PORT_EAST) || (out_idx == `ROUTER_PORT_WEST);
    return (in_idx != out_idx) && !(y_in && x_out);
  endfunction

endpackage

/* design/router_switch.sv */
//--------------------------------------------------------------------------
// Crossbar: routes input requests to per-output arbiters, returns ready
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "router_defines.svh"

module router_switch (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  flit_chan_if.dst                                          in_chan_i [`ROUTER_NUM_PORTS],
  output logic [`ROUTER_NUM_PORTS-1:0]                      valid_o,
  input  logic [`ROUTER_NUM_PORTS-1:0]                      ready_i,
  output logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_FLIT_W-1:0]  data_o
);

  localparam int unsigned N = `ROUTER_NUM_PORTS;

  // Indexed [out][in]
  logic [N-1:0][N-1:0]                     masked_valid;
  logic [N-1:0][N-1:0][`ROUTER_FLIT_W-1:0] masked_data;
  logic [N-1:0][N-1:0]                     gnt;
  // Indexed [in][out]
  logic [N-1:0][N-1:0]                     out_ready;

  for (genvar i = 0; i < N; i++) begin : gen_in
    for (genvar o = 0; o < N; o++) begin : gen_out
      if (router_pkg::conn_allowed(i, o)) begin : gen_conn
        assign masked_valid[o][i] = in_chan_i[i].valid & in_chan_i[i].route[o];
        assign masked_data[o][i]  = in_chan_i[i].data;
        assign out_ready[i][o]    = gnt[o][i] & ready_i[o];
      end else begin : gen_no_conn
        // Loopback and Y-to-X paths cannot occur, tie them off
        assign masked_valid[o][i] = 1'b0;
        assign masked_data[o][i]  = '0;
        assign out_ready[i][o]    = 1'b0;
      end
    end

    // Ready comes from the single output the head flit is routed to
    assign in_chan_i[i].ready = |(out_ready[i] & in_chan_i[i].route);
  end

  for (genvar o = 0; o < N; o++) begin : gen_arb
    router_out_arbiter i_out_arbiter (
      .clk_i   ( clk_i           ),
      .rst_i   ( rst_i           ),
      .req_i   ( masked_valid[o] ),
      .data_i  ( masked_data[o]  ),
      .ready_i ( ready_i[o]      ),
      .gnt_o   ( gnt[o]          ),
      .valid_o ( valid_o[o]      ),
      .data_o  ( data_o[o]       )
    );
  end

endmodule

/* design/router_top.sv */
//--------------------------------------------------------------------------
// Five-port XY mesh router with buffered inputs and round-robin outputs
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "router_defines.svh"

module router_top (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  // Own coordinates, x in the upper nibble
  input  logic [2*`ROUTER_COORD_W-1:0]                      xy_id_i,
  // Input channels
  input  logic [`ROUTER_NUM_PORTS-1:0]                      valid_i,
  output logic [`ROUTER_NUM_PORTS-1:0]                      ready_o,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_FLIT_W-1:0]  data_i,
  // Output channels
  output logic [`ROUTER_NUM_PORTS-1:0]                      valid_o,
  input  logic [`ROUTER_NUM_PORTS-1:0]                      ready_i,
  output logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_FLIT_W-1:0]  data_o
);

  // One channel per input port into the crossbar
  flit_chan_if chan [`ROUTER_NUM_PORTS] ();

  for (genvar i = 0; i < `ROUTER_NUM_PORTS; i++) begin : gen_in_port
    router_in_port i_in_port (
      .clk_i   ( clk_i      ),
      .rst_i   ( rst_i      ),
      .xy_id_i ( xy_id_i    ),
      .valid_i ( valid_i[i] ),
      .ready_o ( ready_o[i] ),
      .data_i  ( data_i[i]  ),
      .chan_o  ( chan[i]    )
    );
  end

  router_switch i_switch (
    .clk_i     ( clk_i   ),
    .rst_i     ( rst_i   ),
    .in_chan_i ( chan    ),
    .valid_o   ( valid_o ),
    .ready_i   ( ready_i ),
    .data_o    ( data_o  )
  );

endmodule

/* dv/router_checker.sv */
//--------------------------------------------------------------------------
// Router handshake assertions, bound to the router top level
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "router_defines.svh"

module router_checker (
  input logic                                              clk_i,
  input logic                                              rst_i,
  input logic [`ROUTER_NUM_PORTS-1:0]                      in_ready_i,
  input logic [`ROUTER_NUM_PORTS-1:0]                      out_valid_i,
  input logic [`ROUTER_NUM_PORTS-1:0]                      out_ready_i,
  input logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_FLIT_W-1:0]  out_data_i
);

  // A stalled output keeps valid and data until the transfer
  for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : gen_port
    out_hold_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (out_valid_i[p] && !out_ready_i[p]) |=> (out_valid_i[p] && $stable(out_data_i[p]))
    ) else $error("Output %0d dropped or changed its flit while stalled", p);
  end

  // Empty buffers accept right after reset
  ready_after_reset_a : assert property (
    @(posedge clk_i) $fell(rst_i) |-> (&in_ready_i)
  ) else $error("Input ready low in the first cycle after reset");

endmodule

bind router_top router_checker i_checker (
  .clk_i       ( clk_i   ),
  .rst_i       ( rst_i   ),
  .in_ready_i  ( ready_o ),
  .out_valid_i ( valid_o ),
  .out_ready_i ( ready_i ),
  .out_data_i  ( data_o  )
);

/* dv/router_tb.sv */
//--------------------------------------------------------------------------
// Mesh router testbench with random XY traffic and a per-pair queue model
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "router_defines.svh"

module router_tb;

  localparam int NP          = `ROUTER_NUM_PORTS;
  localparam int FW          = `ROUTER_FLIT_W;
  localparam int CLK_PERIOD  = 20;
  localparam int ROUTE_FLITS = 2000;
  localparam int BP_FLITS    = 1000;
  localparam int DEPTH_QUOTA = 3;
  localparam int FAIR_QUOTA  = 20;
  localparam int TOTAL_FLITS = ROUTE_FLITS + BP_FLITS + NP * DEPTH_QUOTA + 2 * FAIR_QUOTA;
  localparam int TIMEOUT_CYC = 50 + 12 * TOTAL_FLITS;
  localparam int IDLE_LIMIT  = 64;
  localparam int READY_HIGH  = 0;
  localparam int READY_RAND  = 1;
  localparam int READY_LOW   = 2;
  localparam logic [3:0] OWN_X = 4'd5;
  localparam logic [3:0] OWN_Y = 4'd5;

  logic                   clk_i = 1'b0;
  logic                   rst_i;
  logic [7:0]             xy_id_i;
  logic [NP-1:0]          valid_i;
  logic [NP-1:0]          ready_o;
  logic [NP-1:0][FW-1:0]  data_i;
  logic [NP-1:0]          valid_o;
  logic [NP-1:0]          ready_i;
  logic [NP-1:0][FW-1:0]  data_o;

  // Expected flits in one queue per input and output pair
  logic [FW-1:0] model_q [NP*NP][$];
  logic [31:0]   rng_state = 32'haf3;
  logic [NP-1:0] pending;
  int            issued_cnt [NP];
  int            acc_cnt [NP];
  int            quota;
  int            idle_cyc;
  int            error_cnt;
  int            check_cnt;
  int            test_cnt;
  int            test_err_base;
  int            test_chk_base;
  int            last_fair_src;
  bit            fair_mode;

  router_top UUT (
    .clk_i   ( clk_i   ),
    .rst_i   ( rst_i   ),
    .xy_id_i ( xy_id_i ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .data_i  ( data_i  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .data_o  ( data_o  )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // X is resolved before Y and the local node ejects
  function automatic int expected_port(input logic [3:0] dx, input logic [3:0] dy);
    if (dx != OWN_X) begin
      return (dx > OWN_X) ? `ROUTER_PORT_EAST : `ROUTER_PORT_WEST;
    end
    if (dy != OWN_Y) begin
      return (dy > OWN_Y) ? `ROUTER_PORT_NORTH : `ROUTER_PORT_SOUTH;
    end
    return `ROUTER_PORT_EJECT;
  endfunction

  // Only destinations that a mesh neighbour could legally forward here
  function automatic logic [FW-1:0] make_flit(input int src);
    logic [31:0] r;
    logic [3:0]  dx;
    logic [3:0]  dy;
    r  = next_rand();
    dx = r[3:0];
    dy = r[7:4];
    case (src)
      `ROUTER_PORT_NORTH: begin
        dx = OWN_X;
        dy = 4'(r[7:4] % 4'd6);
      end
      `ROUTER_PORT_SOUTH: begin
        dx = OWN_X;
        dy = 4'(OWN_Y + r[7:4] % 4'd11);
      end
      `ROUTER_PORT_EAST: dx = 4'(r[3:0] % 4'd6);
      `ROUTER_PORT_WEST: dx = 4'(OWN_X + r[3:0] % 4'd11);
      default: begin
        if (dx == OWN_X && dy == OWN_Y) begin
          dy = OWN_Y + 4'd1;
        end
      end
    endcase
    if (fair_mode) begin
      dx = OWN_X;
      dy = OWN_Y;
    end
    // Payload carries the source port in its top bits
    return {dx, dy, 3'(src), r[20:8]};
  endfunction

  task automatic report_mismatch(input string msg);
    error_cnt++;
    $display("mismatch at %0d ns: %s", $time, msg);
  endtask

  task automatic check_output(input int o);
    logic [FW-1:0] flit;
    int            src;
    int            k;
    flit = data_o[o];
    src  = flit[15:13];
    k    = src * NP + o;
    check_cnt++;
    if (expected_port(flit[23:20], flit[19:16]) != o) begin
      report_mismatch($sformatf("flit %h left on wrong output %0d", flit, o));
    end else if (src >= NP || model_q[k].size() == 0) begin
      report_mismatch($sformatf("unexpected flit %h on output %0d", flit, o));
    end else if (model_q[k][0] != flit) begin
      report_mismatch($sformatf("output %0d got %h, expected %h", o, flit, model_q[k][0]));
    end else begin
      void'(model_q[k].pop_front());
    end
    if (fair_mode && o == `ROUTER_PORT_EJECT) begin
      if (src == last_fair_src) begin
        report_mismatch($sformatf("eject output served input %0d twice in a row", src));
      end
      last_fair_src = src;
    end
  endtask

  // Drive on the falling edge and take handshakes on the rising edge
  task automatic run_cycle(input logic [NP-1:0] en, input int ready_mode, input bit always_valid);
    logic [31:0] r;
    bit          moved;
    @(negedge clk_i);
    r = next_rand();
    case (ready_mode)
      READY_HIGH: ready_i = '1;
      READY_RAND: ready_i = r[NP-1:0];
      default:    ready_i = '0;
    endcase
    for (int i = 0; i < NP; i++) begin
      r = next_rand();
      if (!pending[i]) begin
        if (en[i] && issued_cnt[i] < quota && (always_valid || r[0])) begin
          data_i[i]  = make_flit(i);
          valid_i[i] = 1'b1;
          pending[i] = 1'b1;
          issued_cnt[i]++;
        end else begin
          valid_i[i] = 1'b0;
        end
      end
    end
    @(posedge clk_i);
    moved = 1'b0;
    for (int i = 0; i < NP; i++) begin
      if (valid_i[i] && ready_o[i]) begin
        model_q[i * NP + expected_port(data_i[i][23:20], data_i[i][19:16])].push_back(data_i[i]);
        pending[i] = 1'b0;
        acc_cnt[i]++;
        moved = 1'b1;
      end
    end
    for (int o = 0; o < NP; o++) begin
      if (valid_o[o] && ready_i[o]) begin
        check_output(o);
        moved = 1'b1;
      end
    end
    idle_cyc = moved ? 0 : idle_cyc + 1;
  endtask

  function automatic bit traffic_done(input logic [NP-1:0] en);
    for (int i = 0; i < NP; i++) begin
      if (pending[i] || (en[i] && issued_cnt[i] < quota)) begin
        return 1'b0;
      end
    end
    for (int k = 0; k < NP * NP; k++) begin
      if (model_q[k].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Ends when all traffic is delivered or no handshake happens for a while
  task automatic run_until_drained(input logic [NP-1:0] en, input int ready_mode,
                                   input bit always_valid);
    idle_cyc = 0;
    do begin
      run_cycle(en, ready_mode, always_valid);
    end while (!traffic_done(en) && idle_cyc < IDLE_LIMIT);
    if (!traffic_done(en)) begin
      error_cnt++;
      $display("No handshake for %0d cycles while traffic was still in flight", IDLE_LIMIT);
    end
    @(negedge clk_i);
    valid_i = '0;
    pending = '0;
  endtask

  task automatic start_test(input int q);
    quota         = q;
    test_err_base = error_cnt;
    test_chk_base = check_cnt;
    last_fair_src = -1;
    for (int i = 0; i < NP; i++) begin
      issued_cnt[i] = 0;
      acc_cnt[i]    = 0;
    end
  endtask

  task automatic end_test(input string name);
    for (int k = 0; k < NP * NP; k++) begin
      if (model_q[k].size() != 0) begin
        error_cnt++;
        $display("Flits from input %0d to output %0d never left the router", k / NP, k % NP);
        model_q[k].delete();
      end
    end
    test_cnt++;
    $display("Test %s finished: %0d checks, %0d errors", name,
             check_cnt - test_chk_base, error_cnt - test_err_base);
  endtask

  initial begin : watchdog
    #(CLK_PERIOD * TIMEOUT_CYC);
    $display("Run timed out after %0d cycles, traffic never drained", TIMEOUT_CYC);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_i     = 1'b1;
    xy_id_i   = {OWN_X, OWN_Y};
    valid_i   = '0;
    data_i    = '0;
    ready_i   = '0;
    pending   = '0;
    fair_mode = 1'b0;
    error_cnt = 0;
    check_cnt = 0;
    test_cnt  = 0;
    idle_cyc  = 0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    start_test(0);
    @(posedge clk_i);
    check_cnt++;
    if (valid_o != '0 || ready_o != '1) begin
      report_mismatch($sformatf("after reset valid_o=%b ready_o=%b", valid_o, ready_o));
    end
    end_test("reset");

    start_test(ROUTE_FLITS / NP);
    run_until_drained('1, READY_HIGH, 1'b0);
    end_test("routing and order");

    start_test(BP_FLITS / NP);
    run_until_drained('1, READY_RAND, 1'b0);
    end_test("back-pressure");

    // With all outputs stalled each buffer fills and then refuses
    start_test(DEPTH_QUOTA);
    for (int c = 0; c < 10; c++) begin
      run_cycle('1, READY_LOW, 1'b1);
      if (c >= 2) begin
        check_cnt++;
        if (ready_o != '0) begin
          report_mismatch($sformatf("ready_o=%b with full buffers", ready_o));
        end
      end
    end
    for (int i = 0; i < NP; i++) begin
      check_cnt++;
      if (acc_cnt[i] != `ROUTER_IN_FIFO_DEPTH) begin
        report_mismatch($sformatf("input %0d took %0d flits while blocked", i, acc_cnt[i]));
      end
    end
    run_until_drained('1, READY_HIGH, 1'b1);
    end_test("buffer depth");

    fair_mode = 1'b1;
    start_test(FAIR_QUOTA);
    run_until_drained((NP'(1) << `ROUTER_PORT_EAST) | (NP'(1) << `ROUTER_PORT_WEST),
                      READY_HIGH, 1'b1);
    fair_mode = 1'b0;
    end_test("fairness");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+design
design/router_pkg.sv
design/flit_chan_if.sv
design/router_in_port.sv
design/router_out_arbiter.sv
design/router_switch.sv
design/router_top.sv
dv/router_checker.sv
dv/router_tb.sv
